//--- common/id_consts.svh
/* decode stage constants
   data widths, register count and the RV32I major opcodes */

`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// data path and instruction word
`define ID_XLEN      32
`define ID_INS_W     32

// integer register file, x0 included
`define ID_NUM_REGS  32

// major opcodes, instruction bits 6:0
`define ID_OPC_OP     7'b0110011
`define ID_OPC_OP_IMM 7'b0010011
`define ID_OPC_LUI    7'b0110111
`define ID_OPC_AUIPC  7'b0010111
`define ID_OPC_LOAD   7'b0000011

`endif

//--- common/id_pkg.sv
/* shared types of the instruction decode stage */

`default_nettype none

`include "id_consts.svh"

package id_pkg;

    // register values, pc, immediates and operands
    typedef logic [`ID_XLEN-1:0] xlen_t;

    // register index, x0 never written
    typedef logic [$clog2(`ID_NUM_REGS)-1:0] reg_addr_t;

    typedef logic [`ID_INS_W-1:0] ins_word_t;

    // minor opcode, load width at execute
    typedef logic [2:0] funct3_t;

    // alu operation handed to execute
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // unit that completes the instruction
    typedef enum logic {
        zone_alu,
        zone_loadq
    } zone_e;

endpackage

`default_nettype wire

//--- logic/operand_forward.sv
/* operand forwarding and operand selects
   merges in-flight write-back with register file data for execute */

`default_nettype none

`include "id_consts.svh"

module operand_forward (
    input  wire                    clk_i,
    input  wire                    resetb_i,
    input  wire id_pkg::reg_addr_t regs1_addr_i,
    input  wire id_pkg::reg_addr_t regs2_addr_i,
    input  wire id_pkg::xlen_t     rf_s1_i,
    input  wire id_pkg::xlen_t     rf_s2_i,
    input  wire                    wb_wr_i,
    input  wire id_pkg::reg_addr_t wb_addr_i,
    input  wire id_pkg::xlen_t     wb_data_i,
    input  wire id_pkg::xlen_t     pc_i,
    input  wire id_pkg::xlen_t     imm_i,
    input  wire                    sels1_pc_i,
    input  wire                    sels2_imm_i,
    output id_pkg::xlen_t          operand_left_o,
    output id_pkg::xlen_t          operand_right_o
);

    import id_pkg::*;

    // write-back seen one cycle ago
    logic      fwd_wr_q;
    reg_addr_t fwd_addr_q;
    xlen_t     fwd_data_q;

    xlen_t     s1_data;
    xlen_t     s2_data;

    // ------------------------------
    // forwarding register
    // ------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            fwd_wr_q <= 1'b0;
        end else begin
            fwd_wr_q <= wb_wr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        fwd_addr_q <= wb_addr_i;
        fwd_data_q <= wb_data_i;
    end

    // ------------------------------
    // forwarding muxes
    // ------------------------------
    // priority x0, live write-back, forwarding register, register file
    function automatic xlen_t fwd_pick(input reg_addr_t addr, input xlen_t rf_data);
        xlen_t res;
        if (addr == '0) begin
            res = rf_data;
        end else if (wb_wr_i && (wb_addr_i == addr)) begin
            res = wb_data_i;
        end else if (fwd_wr_q && (fwd_addr_q == addr)) begin
            res = fwd_data_q;
        end else begin
            res = rf_data;
        end
        return res;
    endfunction

    always_comb begin
        s1_data = fwd_pick(regs1_addr_i, rf_s1_i);
        s2_data = fwd_pick(regs2_addr_i, rf_s2_i);
    end

    // operand selects
    assign operand_left_o  = sels1_pc_i ? pc_i : s1_data;
    assign operand_right_o = sels2_imm_i ? imm_i : s2_data;

endmodule

`default_nettype wire

//--- regfile/int_regfile.sv
/* integer register file, x0 reads zero
   two write ports, two registered read ports */

`default_nettype none

`include "id_consts.svh"

module int_regfile (
    input  wire                    clk_i,
    input  wire                    resetb_i,
    // write ports
    input  wire                    wr_a_i,
    input  wire id_pkg::reg_addr_t wr_a_addr_i,
    input  wire id_pkg::xlen_t     wr_a_data_i,
    input  wire                    wr_b_i,
    input  wire id_pkg::reg_addr_t wr_b_addr_i,
    input  wire id_pkg::xlen_t     wr_b_data_i,
    // read ports
    input  wire                    rd_a_i,
    input  wire id_pkg::reg_addr_t rd_a_addr_i,
    output id_pkg::xlen_t          rd_a_data_o,
    input  wire                    rd_b_i,
    input  wire id_pkg::reg_addr_t rd_b_addr_i,
    output id_pkg::xlen_t          rd_b_data_o
);

    import id_pkg::*;

    // no storage behind x0
    xlen_t mem [1:`ID_NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (wr_a_i && (wr_a_addr_i != '0)) begin
            mem[wr_a_addr_i] <= wr_a_data_i;
        end
        if (wr_b_i && (wr_b_addr_i != '0)) begin
            mem[wr_b_addr_i] <= wr_b_data_i;
        end
    end

    // read data holds while its enable is low
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rd_a_data_o <= '0;
            rd_b_data_o <= '0;
        end else begin
            if (rd_a_i) begin
                rd_a_data_o <= (rd_a_addr_i == '0) ? '0 : mem[rd_a_addr_i];
            end
            if (rd_b_i) begin
                rd_b_data_o <= (rd_b_addr_i == '0) ? '0 : mem[rd_b_addr_i];
            end
        end
    end

    // execute and load queue never target the same register together
    a_wr_distinct: assert property (@(posedge clk_i) disable iff (!resetb_i)
        wr_a_i && wr_b_i && (wr_a_addr_i != '0) |-> wr_a_addr_i != wr_b_addr_i)
        else $error("both write ports hit one register");

endmodule

`default_nettype wire

//--- id_stage/ins_decoder.sv
/* RV32I decoder for OP, OP-IMM, LUI, AUIPC and LOAD
   instruction word to control fields and immediate, purely combinational */

`default_nettype none

`include "id_consts.svh"

module ins_decoder (
    input  wire id_pkg::ins_word_t ins_i,
    output logic                  uerr_o,
    output id_pkg::zone_e         zone_o,
    output id_pkg::alu_op_e       alu_op_o,
    output id_pkg::funct3_t       funct3_o,
    output logic                  regd_tgt_o,
    output id_pkg::reg_addr_t     regd_addr_o,
    output logic                  regs1_rd_o,
    output id_pkg::reg_addr_t     regs1_addr_o,
    output logic                  regs2_rd_o,
    output id_pkg::reg_addr_t     regs2_addr_o,
    output id_pkg::xlen_t         imm_o,
    output logic                  sels1_pc_o,
    output logic                  sels2_imm_o
);

    import id_pkg::*;

    logic [6:0] opcode;
    funct3_t    funct3;
    logic       funct7_b5;
    logic       alt_sub;
    logic       load_ok;
    xlen_t      imm_i_type;
    xlen_t      imm_u_type;
    alu_op_e    alu_op_f3;

    // fixed instruction fields
    assign opcode      = ins_i[6:0];
    assign funct3      = ins_i[14:12];
    assign funct7_b5   = ins_i[30];
    assign funct3_o    = funct3;
    assign regd_addr_o = ins_i[11:7];
    assign regs2_addr_o = ins_i[24:20];

    assign imm_i_type = {{(`ID_XLEN-12){ins_i[31]}}, ins_i[31:20]};
    assign imm_u_type = {ins_i[31:12], 12'b0};

    // sub exists only in the register form
    assign alt_sub = funct7_b5 & (opcode == `ID_OPC_OP);

    // lb lh lw lbu lhu
    assign load_ok = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);

    // ------------------------------
    // funct3 to alu operation
    // ------------------------------
    always_comb begin
        case (funct3)
            3'b000:  alu_op_f3 = alt_sub ? alu_sub : alu_add;
            3'b001:  alu_op_f3 = alu_sll;
            3'b010:  alu_op_f3 = alu_slt;
            3'b011:  alu_op_f3 = alu_sltu;
            3'b100:  alu_op_f3 = alu_xor;
            3'b101:  alu_op_f3 = funct7_b5 ? alu_sra : alu_srl;
            3'b110:  alu_op_f3 = alu_or;
            default: alu_op_f3 = alu_and;
        endcase
    end

    // ------------------------------
    // opcode decode
    // ------------------------------
    always_comb begin
        uerr_o       = 1'b0;
        zone_o       = zone_alu;
        alu_op_o     = alu_add;
        regd_tgt_o   = 1'b0;
        regs1_rd_o   = 1'b0;
        regs1_addr_o = ins_i[19:15];
        regs2_rd_o   = 1'b0;
        imm_o        = imm_i_type;
        sels1_pc_o   = 1'b0;
        sels2_imm_o  = 1'b0;
        case (opcode)
            `ID_OPC_OP: begin
                regd_tgt_o = 1'b1;
                regs1_rd_o = 1'b1;
                regs2_rd_o = 1'b1;
                alu_op_o   = alu_op_f3;
            end
            `ID_OPC_OP_IMM: begin
                regd_tgt_o  = 1'b1;
                regs1_rd_o  = 1'b1;
                sels2_imm_o = 1'b1;
                alu_op_o    = alu_op_f3;
            end
            `ID_OPC_LUI: begin
                // x0 + imm, x0 read so the left operand is zero
                regd_tgt_o   = 1'b1;
                regs1_rd_o   = 1'b1;
                regs1_addr_o = '0;
                sels2_imm_o  = 1'b1;
                imm_o        = imm_u_type;
            end
            `ID_OPC_AUIPC: begin
                regd_tgt_o  = 1'b1;
                sels1_pc_o  = 1'b1;
                sels2_imm_o = 1'b1;
                imm_o       = imm_u_type;
            end
            `ID_OPC_LOAD: begin
                // address is rs1 + imm, width stays in funct3
                if (load_ok) begin
                    regd_tgt_o  = 1'b1;
                    regs1_rd_o  = 1'b1;
                    sels2_imm_o = 1'b1;
                    zone_o      = zone_loadq;
                end else begin
                    uerr_o = 1'b1;
                end
            end
            default: begin
                uerr_o = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- id_stage/load_scoreboard.sv
/* pending-load scoreboard
   one flag per register with a load in flight, stalls dependent instructions */

`default_nettype none

`include "id_consts.svh"

module load_scoreboard (
    input  wire                    clk_i,
    input  wire                    resetb_i,
    input  wire                    dav_i,
    input  wire                    ack_i,
    input  wire                    load_i,
    input  wire                    regs1_rd_i,
    input  wire id_pkg::reg_addr_t regs1_addr_i,
    input  wire                    regs2_rd_i,
    input  wire id_pkg::reg_addr_t regs2_addr_i,
    input  wire                    regd_tgt_i,
    input  wire id_pkg::reg_addr_t regd_addr_i,
    input  wire                    cncl_i,
    input  wire id_pkg::reg_addr_t cncl_addr_i,
    input  wire                    lsq_wr_i,
    input  wire id_pkg::reg_addr_t lsq_addr_i,
    output logic                   stall_o
);

    import id_pkg::*;

    logic [`ID_NUM_REGS-1:1] pending_q;
    // x0 slot tied low
    logic [`ID_NUM_REGS-1:0] pend_all;
    logic [`ID_NUM_REGS-1:0] pend_nxt;
    logic                    set_en;

    assign pend_all = {pending_q, 1'b0};
    assign set_en   = ack_i & load_i & regd_tgt_i & (regd_addr_i != '0);

    // stall on a pending source or target
    always_comb begin
        stall_o = 1'b0;
        if (dav_i) begin
            if ((regs1_rd_i && pend_all[regs1_addr_i]) ||
                (regs2_rd_i && pend_all[regs2_addr_i]) ||
                (regd_tgt_i && pend_all[regd_addr_i])) begin
                stall_o = 1'b1;
            end
        end
    end

    // load issue sets, cancel or load-queue write clears
    always_comb begin
        pend_nxt = pend_all;
        if (set_en) begin
            pend_nxt[regd_addr_i] = 1'b1;
        end
        if (cncl_i) begin
            pend_nxt[cncl_addr_i] = 1'b0;
        end
        if (lsq_wr_i) begin
            pend_nxt[lsq_addr_i] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pend_nxt[`ID_NUM_REGS-1:1];
        end
    end

    a_set_free: assert property (@(posedge clk_i) disable iff (!resetb_i)
        set_en |-> !pend_all[regd_addr_i])
        else $error("load issued to a register already pending");

    a_cncl_pending: assert property (@(posedge clk_i) disable iff (!resetb_i)
        cncl_i && (cncl_addr_i != '0) |-> pend_all[cncl_addr_i])
        else $error("load cancel for a register not pending");

    a_lsq_pending: assert property (@(posedge clk_i) disable iff (!resetb_i)
        lsq_wr_i && (lsq_addr_i != '0) |-> pend_all[lsq_addr_i])
        else $error("load queue write to a register not pending");

endmodule

`default_nettype wire

//--- id_stage/id_stage.sv
/* instruction decode stage
   takes one instruction per fetch handshake, reads and forwards operands,
   stalls on pending loads and registers the result towards execute */

`default_nettype none

`include "id_consts.svh"

module id_stage (
    input  wire                   clk_i,
    input  wire                   resetb_i,
    // fetch side
    input  wire                   pfu_dav_i,
    output logic                  pfu_ack_o,
    input  wire id_pkg::ins_word_t pfu_ins_i,
    input  wire id_pkg::xlen_t    pfu_pc_i,
    // execute side
    output logic                  exs_valid_o,
    input  wire                   exs_stall_i,
    output logic                  exs_ins_uerr_o,
    output id_pkg::zone_e         exs_zone_o,
    output id_pkg::alu_op_e       exs_alu_op_o,
    output id_pkg::funct3_t       exs_funct3_o,
    output id_pkg::reg_addr_t     exs_regd_addr_o,
    output id_pkg::xlen_t         exs_pc_o,
    output id_pkg::xlen_t         exs_operand_left_o,
    output id_pkg::xlen_t         exs_operand_right_o,
    // write-back from execute
    input  wire                   exs_regd_wr_i,
    input  wire                   exs_regd_cncl_load_i,
    input  wire id_pkg::reg_addr_t exs_regd_addr_i,
    input  wire id_pkg::xlen_t    exs_regd_data_i,
    // write-back from load queue
    input  wire                   lsq_reg_wr_i,
    input  wire id_pkg::reg_addr_t lsq_reg_addr_i,
    input  wire id_pkg::xlen_t    lsq_reg_data_i
);

    import id_pkg::*;

    // decoder outputs
    logic      ins_uerr_d;
    zone_e     zone_d;
    alu_op_e   alu_op_d;
    funct3_t   funct3_d;
    logic      regd_tgt_d;
    reg_addr_t regd_addr_d;
    logic      regs1_rd_d;
    reg_addr_t regs1_addr_d;
    logic      regs2_rd_d;
    reg_addr_t regs2_addr_d;
    xlen_t     imm_d;
    logic      sels1_pc_d;
    logic      sels2_imm_d;

    // qualifier
    logic      ids_stall;
    logic      slot_free;

    // register file read side
    logic      rf_rd_a;
    logic      rf_rd_b;
    reg_addr_t rf_addr_a;
    reg_addr_t rf_addr_b;
    xlen_t     rf_s1;
    xlen_t     rf_s2;

    // decode-to-execute payload
    xlen_t     imm_q;
    logic      sels1_pc_q;
    logic      sels2_imm_q;
    reg_addr_t regs1_addr_q;
    reg_addr_t regs2_addr_q;

    // ------------------------------
    // fetch qualifier
    // ------------------------------
    // slot frees when execute takes the current one or holds nothing
    assign slot_free = ~exs_stall_i | ~exs_valid_o;
    assign pfu_ack_o = pfu_dav_i & ~ids_stall & slot_free;

    ins_decoder decoder_i (
        .ins_i        (pfu_ins_i),
        .uerr_o       (ins_uerr_d),
        .zone_o       (zone_d),
        .alu_op_o     (alu_op_d),
        .funct3_o     (funct3_d),
        .regd_tgt_o   (regd_tgt_d),
        .regd_addr_o  (regd_addr_d),
        .regs1_rd_o   (regs1_rd_d),
        .regs1_addr_o (regs1_addr_d),
        .regs2_rd_o   (regs2_rd_d),
        .regs2_addr_o (regs2_addr_d),
        .imm_o        (imm_d),
        .sels1_pc_o   (sels1_pc_d),
        .sels2_imm_o  (sels2_imm_d)
    );

    load_scoreboard scoreboard_i (
        .clk_i        (clk_i),
        .resetb_i     (resetb_i),
        .dav_i        (pfu_dav_i),
        .ack_i        (pfu_ack_o),
        .load_i       (zone_d == zone_loadq),
        .regs1_rd_i   (regs1_rd_d),
        .regs1_addr_i (regs1_addr_d),
        .regs2_rd_i   (regs2_rd_d),
        .regs2_addr_i (regs2_addr_d),
        .regd_tgt_i   (regd_tgt_d),
        .regd_addr_i  (regd_addr_d),
        .cncl_i       (exs_regd_cncl_load_i),
        .cncl_addr_i  (exs_regd_addr_i),
        .lsq_wr_i     (lsq_reg_wr_i),
        .lsq_addr_i   (lsq_reg_addr_i),
        .stall_o      (ids_stall)
    );

    // ------------------------------
    // register file reads
    // ------------------------------
    // new sources on ack or a refresh of the held sources
    // so late writes survive past the forwarding register
    assign rf_rd_a   = pfu_ack_o ? regs1_rd_d : exs_valid_o;
    assign rf_rd_b   = pfu_ack_o ? regs2_rd_d : exs_valid_o;
    assign rf_addr_a = pfu_ack_o ? regs1_addr_d : regs1_addr_q;
    assign rf_addr_b = pfu_ack_o ? regs2_addr_d : regs2_addr_q;

    int_regfile regfile_i (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .wr_a_i      (exs_regd_wr_i),
        .wr_a_addr_i (exs_regd_addr_i),
        .wr_a_data_i (exs_regd_data_i),
        .wr_b_i      (lsq_reg_wr_i),
        .wr_b_addr_i (lsq_reg_addr_i),
        .wr_b_data_i (lsq_reg_data_i),
        .rd_a_i      (rf_rd_a),
        .rd_a_addr_i (rf_addr_a),
        .rd_a_data_o (rf_s1),
        .rd_b_i      (rf_rd_b),
        .rd_b_addr_i (rf_addr_b),
        .rd_b_data_o (rf_s2)
    );

    // ------------------------------
    // decode-to-execute stage
    // ------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            exs_valid_o <= 1'b0;
        end else if (slot_free) begin
            exs_valid_o <= pfu_ack_o;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk_i) begin
        if (pfu_ack_o) begin
            exs_ins_uerr_o  <= ins_uerr_d;
            exs_zone_o      <= zone_d;
            exs_alu_op_o    <= alu_op_d;
            exs_funct3_o    <= funct3_d;
            exs_regd_addr_o <= regd_addr_d;
            exs_pc_o        <= pfu_pc_i;
            imm_q           <= imm_d;
            sels1_pc_q      <= sels1_pc_d;
            sels2_imm_q     <= sels2_imm_d;
            regs1_addr_q    <= regs1_addr_d;
            regs2_addr_q    <= regs2_addr_d;
        end
    end

    operand_forward forward_i (
        .clk_i           (clk_i),
        .resetb_i        (resetb_i),
        .regs1_addr_i    (regs1_addr_q),
        .regs2_addr_i    (regs2_addr_q),
        .rf_s1_i         (rf_s1),
        .rf_s2_i         (rf_s2),
        .wb_wr_i         (exs_regd_wr_i),
        .wb_addr_i       (exs_regd_addr_i),
        .wb_data_i       (exs_regd_data_i),
        .pc_i            (exs_pc_o),
        .imm_i           (imm_q),
        .sels1_pc_i      (sels1_pc_q),
        .sels2_imm_i     (sels2_imm_q),
        .operand_left_o  (exs_operand_left_o),
        .operand_right_o (exs_operand_right_o)
    );

    // no ack without an offered instruction
    a_ack_needs_dav: assert property (@(posedge clk_i) disable iff (!resetb_i)
        pfu_ack_o |-> pfu_dav_i)
        else $error("fetch ack while dav low");

endmodule

`default_nettype wire

//--- sim/tb_id_stage.sv
/* directed testbench of the decode stage
   reference decoder, register shadow model and pending-load sequences */

`default_nettype none

`include "id_consts.svh"

module tb_id_stage;

    import id_pkg::*;

    localparam int CYCLE_LIMIT = 4000;
    localparam logic [31:0] LFSR_SEED = 32'd68;

    logic clk_i = 1'b0;
    logic resetb_i;
    logic pfu_dav_i;
    logic pfu_ack_o;
    logic exs_stall_i;
    logic exs_valid_o;
    logic exs_ins_uerr_o;
    ins_word_t pfu_ins_i;
    xlen_t pfu_pc_i;
    xlen_t exs_pc_o;
    xlen_t exs_operand_left_o;
    xlen_t exs_operand_right_o;
    zone_e exs_zone_o;
    alu_op_e exs_alu_op_o;
    funct3_t exs_funct3_o;
    reg_addr_t exs_regd_addr_o;
    reg_addr_t exs_regd_addr_i;
    reg_addr_t lsq_reg_addr_i;
    logic exs_regd_wr_i;
    logic exs_regd_cncl_load_i;
    logic lsq_reg_wr_i;
    xlen_t exs_regd_data_i;
    xlen_t lsq_reg_data_i;

    // shadow of the architectural registers
    xlen_t regs_model [0:31];
    logic [31:0] lfsr_q = LFSR_SEED;
    int cycles = 0;

    id_stage dut_i (.*);

    always #4 clk_i = ~clk_i;

    // runaway guard
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Checks failed");
            $fatal(1, "run exceeded the cycle limit, handshake never completed");
        end
    end

    // galois lfsr stepped once per bit
    task automatic get_rand(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %08h expected %08h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ------------------------------
    // reference decoder
    // ------------------------------
    task automatic ref_decode(input ins_word_t ins, input xlen_t pc, output logic uerr,
                              output zone_e zone, output alu_op_e op, output xlen_t left,
                              output xlen_t right);
        logic [6:0] opc;
        logic [2:0] f3;
        xlen_t imm_i;
        xlen_t imm_u;
        opc = ins[6:0];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'b0};
        uerr = 1'b0;
        zone = zone_alu;
        op = alu_add;
        left = regs_model[ins[19:15]];
        right = imm_i;
        case (f3)
            3'd0: op = (opc == `ID_OPC_OP && ins[30]) ? alu_sub : alu_add;
            3'd1: op = alu_sll;
            3'd2: op = alu_slt;
            3'd3: op = alu_sltu;
            3'd4: op = alu_xor;
            3'd5: op = ins[30] ? alu_sra : alu_srl;
            3'd6: op = alu_or;
            default: op = alu_and;
        endcase
        if (opc == `ID_OPC_OP) begin
            right = regs_model[ins[24:20]];
        end else if (opc == `ID_OPC_OP_IMM) begin
            right = imm_i;
        end else if (opc == `ID_OPC_LUI || opc == `ID_OPC_AUIPC) begin
            op = alu_add;
            right = imm_u;
            left = (opc == `ID_OPC_LUI) ? '0 : pc;
        end else if (opc == `ID_OPC_LOAD) begin
            op = alu_add;
            zone = zone_loadq;
            uerr = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
        end else begin
            uerr = 1'b1;
        end
    endtask

    task automatic wb_write(input reg_addr_t addr, input xlen_t data);
        @(negedge clk_i);
        exs_regd_wr_i = 1'b1;
        exs_regd_addr_i = addr;
        exs_regd_data_i = data;
        @(negedge clk_i);
        exs_regd_wr_i = 1'b0;
        if (addr != 0) begin
            regs_model[addr] = data;
        end
    endtask

    task automatic offer(input ins_word_t ins, input xlen_t pc);
        @(negedge clk_i);
        pfu_dav_i = 1'b1;
        pfu_ins_i = ins;
        pfu_pc_i = pc;
    endtask

    // wait for ack and let the edge transfer before dropping dav
    task automatic complete_transfer;
        #1;
        while (!pfu_ack_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        pfu_dav_i = 1'b0;
    endtask

    task automatic check_exs(input ins_word_t ins, input xlen_t pc);
        logic uerr;
        zone_e zone;
        alu_op_e op;
        xlen_t left;
        xlen_t right;
        ref_decode(ins, pc, uerr, zone, op, left, right);
        #1;
        check_val("exs_valid_o", exs_valid_o, 1);
        check_val("exs_ins_uerr_o", exs_ins_uerr_o, uerr);
        check_val("exs_pc_o", exs_pc_o, pc);
        if (!uerr) begin
            check_val("exs_zone_o", exs_zone_o, zone);
            check_val("exs_alu_op_o", exs_alu_op_o, op);
            check_val("exs_funct3_o", exs_funct3_o, ins[14:12]);
            check_val("exs_regd_addr_o", exs_regd_addr_o, ins[11:7]);
            check_val("exs_operand_left_o", exs_operand_left_o, left);
            check_val("exs_operand_right_o", exs_operand_right_o, right);
        end
    endtask

    task automatic issue_check(input ins_word_t ins, input xlen_t pc);
        offer(ins, pc);
        complete_transfer();
        check_exs(ins, pc);
    endtask

    function automatic ins_word_t enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_reset_idle;
        @(negedge clk_i);
        #1;
        check_val("exs_valid_o", exs_valid_o, 0);
        check_val("pfu_ack_o", pfu_ack_o, 0);
        offer(enc(7'h0, 5'd5, 5'd0, 3'd0, 5'd9, `ID_OPC_OP_IMM), 32'h100);
        #1;
        check_val("pfu_ack_o", pfu_ack_o, 1);
        complete_transfer();
        check_exs(enc(7'h0, 5'd5, 5'd0, 3'd0, 5'd9, `ID_OPC_OP_IMM), 32'h100);
    endtask

    task automatic test_alu_decode;
        logic [31:0] r;
        logic [31:0] s;
        for (int i = 1; i <= 12; i++) begin
            get_rand(32, r);
            wb_write(i[4:0], r);
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int alt = 0; alt < 2; alt++) begin
                get_rand(4, r);
                get_rand(4, s);
                issue_check(enc(alt ? 7'h20 : 7'h0, 5'd1 + s[3:0] % 12, 5'd1 + r[3:0] % 12,
                                f3[2:0], 5'd13 + r[2:0], `ID_OPC_OP), 32'h200 + f3 * 8);
                get_rand(12, r);
                // bit 30 follows alt so srai and srli are both issued
                issue_check(enc({r[11], alt[0], r[10:6]}, r[4:0], 5'd1 + r[3:0] % 12, f3[2:0],
                                5'd20 + s[2:0], `ID_OPC_OP_IMM), 32'h300 + f3 * 8);
            end
        end
    endtask

    task automatic test_upper_imm;
        logic [31:0] r;
        logic [31:0] pc;
        for (int i = 0; i < 6; i++) begin
            get_rand(32, r);
            get_rand(30, pc);
            issue_check({r[31:12], 5'd10, (i % 2) ? `ID_OPC_AUIPC : `ID_OPC_LUI}, pc << 2);
        end
    endtask

    task automatic test_forwarding;
        ins_word_t ins;
        logic [31:0] d1;
        logic [31:0] d2;
        ins = enc(7'h0, 5'd4, 5'd3, 3'd0, 5'd11, `ID_OPC_OP);
        get_rand(32, d1);
        get_rand(32, d2);
        // write rs1 in the acceptance cycle
        offer(ins, 32'h400);
        exs_regd_wr_i = 1'b1;
        exs_regd_addr_i = 5'd3;
        exs_regd_data_i = d1;
        regs_model[3] = d1;
        complete_transfer();
        exs_regd_wr_i = 1'b0;
        exs_stall_i = 1'b1;
        check_exs(ins, 32'h400);
        // write rs2 while held at execute
        @(negedge clk_i);
        exs_regd_wr_i = 1'b1;
        exs_regd_addr_i = 5'd4;
        exs_regd_data_i = d2;
        regs_model[4] = d2;
        check_exs(ins, 32'h400);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk_i);
            exs_regd_wr_i = 1'b0;
            check_exs(ins, 32'h400);
        end
        @(negedge clk_i);
        exs_stall_i = 1'b0;
    endtask

    task automatic test_load_hazard(input logic use_cancel);
        ins_word_t dep;
        logic [31:0] d;
        dep = enc(7'h0, 5'd1, 5'd7, 3'd0, 5'd8, `ID_OPC_OP);
        issue_check(enc(7'h0, 5'd4, 5'd2, 3'd2, 5'd7, `ID_OPC_LOAD), 32'h500);
        offer(dep, 32'h504);
        for (int i = 0; i < 4; i++) begin
            #1;
            check_val("pfu_ack_o", pfu_ack_o, 0);
            @(negedge clk_i);
        end
        get_rand(32, d);
        if (use_cancel) begin
            exs_regd_cncl_load_i = 1'b1;
            exs_regd_addr_i = 5'd7;
        end else begin
            lsq_reg_wr_i = 1'b1;
            lsq_reg_addr_i = 5'd7;
            lsq_reg_data_i = d;
            regs_model[7] = d;
        end
        #1;
        check_val("pfu_ack_o", pfu_ack_o, 0);
        @(negedge clk_i);
        exs_regd_cncl_load_i = 1'b0;
        lsq_reg_wr_i = 1'b0;
        complete_transfer();
        check_exs(dep, 32'h504);
    endtask

    task automatic test_stall_errors;
        ins_word_t a;
        ins_word_t b;
        a = enc(7'h0, 5'd2, 5'd1, 3'd4, 5'd12, `ID_OPC_OP);
        b = enc(7'h0, 5'd3, 5'd5, 3'd6, 5'd14, `ID_OPC_OP_IMM);
        offer(a, 32'h600);
        complete_transfer();
        // hold execute and offer the next instruction
        exs_stall_i = 1'b1;
        pfu_dav_i = 1'b1;
        pfu_ins_i = b;
        pfu_pc_i = 32'h604;
        for (int i = 0; i < 3; i++) begin
            #1;
            check_val("pfu_ack_o", pfu_ack_o, 0);
            check_exs(a, 32'h600);
            @(negedge clk_i);
        end
        exs_stall_i = 1'b0;
        complete_transfer();
        check_exs(b, 32'h604);
        issue_check(32'h0000007F, 32'h608);
        issue_check(enc(7'h0, 5'd0, 5'd1, 3'd7, 5'd9, `ID_OPC_LOAD), 32'h60C);
    endtask

    initial begin
        resetb_i = 1'b0;
        pfu_dav_i = 1'b0;
        pfu_ins_i = '0;
        pfu_pc_i = '0;
        exs_stall_i = 1'b0;
        exs_regd_wr_i = 1'b0;
        exs_regd_cncl_load_i = 1'b0;
        exs_regd_addr_i = '0;
        exs_regd_data_i = '0;
        lsq_reg_wr_i = 1'b0;
        lsq_reg_addr_i = '0;
        lsq_reg_data_i = '0;
        for (int i = 0; i < 32; i++) begin
            regs_model[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        resetb_i = 1'b1;
        test_reset_idle();
        test_alu_decode();
        test_upper_imm();
        test_forwarding();
        test_load_hazard(1'b0);
        test_load_hazard(1'b1);
        test_stall_errors();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/id_pkg.sv
logic/operand_forward.sv
regfile/int_regfile.sv
id_stage/ins_decoder.sv
id_stage/load_scoreboard.sv
id_stage/id_stage.sv
sim/tb_id_stage.sv
